// File: hw/proj_mem_pkg.sv
package proj_mem_pkg;

    // SRAM port geometry
    localparam int addr_w = 16;
    localparam int data_w = 32;
    localparam int dim_w  = 16;

    // Header sits at the bottom, operands follow it
    localparam logic [addr_w-1:0] header_addr = 16'd0;
    localparam logic [addr_w-1:0] data_base   = 16'd1;

    // One SRAM word, read as a dimension header at address 0
    // and as a raw operand or result everywhere else
    typedef union packed {
        struct packed {
            logic [dim_w-1:0] rows;
            logic [dim_w-1:0] cols;
        } dims;
        logic [data_w-1:0] raw;
    } sram_word_u;

endpackage

// File: hw/proj_ctrl_pkg.sv
package proj_ctrl_pkg;

    // Weight matrix select codes, in result order
    localparam int mat_sel_w = 2;
    localparam logic [mat_sel_w-1:0] mat_q = 2'd0;
    localparam logic [mat_sel_w-1:0] mat_k = 2'd1;
    localparam logic [mat_sel_w-1:0] mat_v = 2'd2;

    // Number of projections computed per run
    localparam int num_mat = 3;

    // Cycles from a sampled read address to its data
    localparam int read_latency = 1;

endpackage

// File: hw/proj_decode.sv
`timescale 1ns/10ps

module proj_decode (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          dut_valid,
    output logic                          dut_ready,
    input  proj_mem_pkg::sram_word_u      input_read_data,
    input  proj_mem_pkg::sram_word_u      weight_read_data,
    input  logic                          done,
    output logic                          run,
    output logic [proj_mem_pkg::dim_w-1:0] input_rows,
    output logic [proj_mem_pkg::dim_w-1:0] input_cols,
    output logic [proj_mem_pkg::dim_w-1:0] weight_cols
);

    // One-hot controller, dut_ready doubles as the idle state
    logic header_phase;
    logic busy;
    logic start;

    // Strobes while busy are dropped
    assign start = dut_ready && dut_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dut_ready    <= 1'b1;
            header_phase <= 1'b0;
            busy         <= 1'b0;
            run          <= 1'b0;
        end else begin
            run <= 1'b0;

            if (start) begin
                dut_ready    <= 1'b0;
                header_phase <= 1'b1;
            end

            // Headers are on the read ports now, kick off the sweep
            if (header_phase) begin
                header_phase <= 1'b0;
                busy         <= 1'b1;
                run          <= 1'b1;
            end

            if (busy && done) begin
                busy      <= 1'b0;
                dut_ready <= 1'b1;
            end
        end
    end

    // Idle read addresses are the header address, so the words
    // are already valid one cycle after the strobe.
    // Weight rows are assumed to equal input cols and are not kept
    always_ff @(posedge clk) begin
        if (header_phase) begin
            input_rows  <= input_read_data.dims.rows;
            input_cols  <= input_read_data.dims.cols;
            weight_cols <= weight_read_data.dims.cols;
        end
    end

endmodule

// File: hw/proj_execute.sv
`timescale 1ns/10ps

module proj_execute (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           run,
    input  logic [proj_mem_pkg::dim_w-1:0]  input_rows,
    input  logic [proj_mem_pkg::dim_w-1:0]  input_cols,
    input  logic [proj_mem_pkg::dim_w-1:0]  weight_cols,
    output logic [proj_mem_pkg::addr_w-1:0] input_read_address,
    output logic [proj_mem_pkg::addr_w-1:0] weight_read_address,
    input  proj_mem_pkg::sram_word_u       input_read_data,
    input  proj_mem_pkg::sram_word_u       weight_read_data,
    output logic                           elem_valid,
    output proj_mem_pkg::sram_word_u       elem_value
);

    import proj_mem_pkg::*;
    import proj_ctrl_pkg::*;

    // Sweep state
    logic                 active;
    logic [mat_sel_w-1:0] mat_sel;
    logic [dim_w-1:0]     row_idx;
    logic [dim_w-1:0]     col_idx;
    logic [dim_w-1:0]     k_idx;
    logic [addr_w-1:0]    in_row_base;
    logic [addr_w-1:0]    w_col_base;
    logic [addr_w-1:0]    mat_size;
    logic [addr_w-1:0]    mat_base;

    logic last_k;
    logic last_col;
    logic last_row;
    logic last_mat;

    // Pair flags, stage 0 loads at issue
    logic [read_latency:0] pipe_valid;
    logic [read_latency:0] pipe_first;
    logic [read_latency:0] pipe_last;

    logic [data_w-1:0] product;
    logic [data_w-1:0] acc_sum;

    assign last_k   = (k_idx == input_cols - 1'b1);
    assign last_col = (col_idx == weight_cols - 1'b1);
    assign last_row = (row_idx == input_rows - 1'b1);
    assign last_mat = (mat_sel == mat_v);

    // Start of the current weight matrix
    always_comb begin
        case (mat_sel)
            mat_q:   mat_base = '0;
            mat_k:   mat_base = mat_size;
            mat_v:   mat_base = mat_size + mat_size;
            default: mat_base = '0;
        endcase
    end

    // Words per weight matrix, fixed for the whole run
    always_ff @(posedge clk) begin
        if (run) begin
            mat_size <= input_cols * weight_cols;
        end
    end

    // Matrix, row, column, k order; one read pair per cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active              <= 1'b0;
            mat_sel             <= mat_q;
            row_idx             <= '0;
            col_idx             <= '0;
            k_idx               <= '0;
            in_row_base         <= '0;
            w_col_base          <= '0;
            input_read_address  <= header_addr;
            weight_read_address <= header_addr;
        end else if (run) begin
            active      <= 1'b1;
            mat_sel     <= mat_q;
            row_idx     <= '0;
            col_idx     <= '0;
            k_idx       <= '0;
            in_row_base <= '0;
            w_col_base  <= '0;
        end else if (active) begin
            // Input is row-major, weights column-major
            input_read_address  <= data_base + in_row_base + k_idx;
            weight_read_address <= data_base + w_col_base + k_idx;

            if (!last_k) begin
                k_idx <= k_idx + 1'b1;
            end else begin
                k_idx <= '0;
                if (!last_col) begin
                    col_idx    <= col_idx + 1'b1;
                    w_col_base <= w_col_base + input_cols;
                end else begin
                    col_idx <= '0;
                    if (!last_row) begin
                        row_idx     <= row_idx + 1'b1;
                        in_row_base <= in_row_base + input_cols;
                        w_col_base  <= mat_base;
                    end else begin
                        row_idx     <= '0;
                        in_row_base <= '0;
                        // Next matrix starts right after the last column
                        w_col_base  <= w_col_base + input_cols;
                        if (!last_mat) begin
                            mat_sel <= mat_sel + 1'b1;
                        end else begin
                            active <= 1'b0;
                        end
                    end
                end
            end
        end else begin
            input_read_address  <= header_addr;
            weight_read_address <= header_addr;
        end
    end

    // Flags ride alongside the SRAM read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pipe_valid <= '0;
            pipe_first <= '0;
            pipe_last  <= '0;
            elem_valid <= 1'b0;
        end else begin
            pipe_valid <= {pipe_valid[read_latency-1:0], active};
            pipe_first <= {pipe_first[read_latency-1:0], k_idx == '0};
            pipe_last  <= {pipe_last[read_latency-1:0], last_k};
            elem_valid <= pipe_valid[read_latency] && pipe_last[read_latency];
        end
    end

    // Wraps modulo 2^32
    assign product = input_read_data.raw * weight_read_data.raw;

    always_ff @(posedge clk) begin
        if (pipe_valid[read_latency]) begin
            acc_sum <= pipe_first[read_latency] ? product : acc_sum + product;
        end
    end

    assign elem_value.raw = acc_sum;

endmodule

// File: hw/proj_result.sv
`timescale 1ns/10ps

module proj_result (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           run,
    input  logic [proj_mem_pkg::dim_w-1:0]  input_rows,
    input  logic [proj_mem_pkg::dim_w-1:0]  weight_cols,
    input  logic                           elem_valid,
    input  proj_mem_pkg::sram_word_u       elem_value,
    output logic                           write_enable,
    output logic [proj_mem_pkg::addr_w-1:0] write_address,
    output proj_mem_pkg::sram_word_u       write_data,
    output logic                           done
);

    import proj_mem_pkg::*;
    import proj_ctrl_pkg::*;

    logic [addr_w-1:0] elem_count;
    logic [addr_w-1:0] elem_total;

    // Q, K and V are packed back to back
    always_ff @(posedge clk) begin
        if (run) begin
            elem_total <= addr_w'(num_mat) * input_rows * weight_cols;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            elem_count   <= '0;
            write_enable <= 1'b0;
            done         <= 1'b0;
        end else begin
            write_enable <= elem_valid;
            done         <= write_enable && (write_address == elem_total - 1'b1);
            if (run) begin
                elem_count <= '0;
            end else if (elem_valid) begin
                elem_count <= elem_count + 1'b1;
            end
        end
    end

    // Running address, results arrive in row-major order
    always_ff @(posedge clk) begin
        if (elem_valid) begin
            write_address <= elem_count;
            write_data    <= elem_value;
        end
    end

endmodule

// File: hw/attn_proj_top.sv
`timescale 1ns/10ps

module attn_proj_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           dut_valid,
    output logic                           dut_ready,
    output logic [proj_mem_pkg::addr_w-1:0] sram_input_read_address,
    input  proj_mem_pkg::sram_word_u       sram_input_read_data,
    output logic [proj_mem_pkg::addr_w-1:0] sram_weight_read_address,
    input  proj_mem_pkg::sram_word_u       sram_weight_read_data,
    output logic                           sram_result_write_enable,
    output logic [proj_mem_pkg::addr_w-1:0] sram_result_write_address,
    output proj_mem_pkg::sram_word_u       sram_result_write_data
);

    import proj_mem_pkg::*;

    logic             run;
    logic             done;
    logic [dim_w-1:0] input_rows;
    logic [dim_w-1:0] input_cols;
    logic [dim_w-1:0] weight_cols;
    logic             elem_valid;
    sram_word_u       elem_value;

    // Strobe, header capture and busy flag
    proj_decode u_decode (
        .clk              (clk),
        .reset_n          (reset_n),
        .dut_valid        (dut_valid),
        .dut_ready        (dut_ready),
        .input_read_data  (sram_input_read_data),
        .weight_read_data (sram_weight_read_data),
        .done             (done),
        .run              (run),
        .input_rows       (input_rows),
        .input_cols       (input_cols),
        .weight_cols      (weight_cols)
    );

    // Read sweep and MAC pipeline
    proj_execute u_execute (
        .clk                 (clk),
        .reset_n             (reset_n),
        .run                 (run),
        .input_rows          (input_rows),
        .input_cols          (input_cols),
        .weight_cols         (weight_cols),
        .input_read_address  (sram_input_read_address),
        .weight_read_address (sram_weight_read_address),
        .input_read_data     (sram_input_read_data),
        .weight_read_data    (sram_weight_read_data),
        .elem_valid          (elem_valid),
        .elem_value          (elem_value)
    );

    proj_result u_result (
        .clk           (clk),
        .reset_n       (reset_n),
        .run           (run),
        .input_rows    (input_rows),
        .weight_cols   (weight_cols),
        .elem_valid    (elem_valid),
        .elem_value    (elem_value),
        .write_enable  (sram_result_write_enable),
        .write_address (sram_result_write_address),
        .write_data    (sram_result_write_data),
        .done          (done)
    );

endmodule

// File: bench/tb_attn_proj.sv
`timescale 1ns/10ps

module tb_attn_proj;

    import proj_mem_pkg::*;

    localparam int mem_depth     = 1 << addr_w;
    localparam int mats_per_case = 3;
    localparam int case_overhead = 20;
    localparam int cycle_margin  = 100;

    logic              clk;
    logic              reset_n;
    logic              dut_valid;
    logic              dut_ready;
    logic [addr_w-1:0] sram_input_read_address;
    logic [addr_w-1:0] sram_weight_read_address;
    sram_word_u        sram_input_read_data = '0;
    sram_word_u        sram_weight_read_data = '0;
    logic              sram_result_write_enable;
    logic [addr_w-1:0] sram_result_write_address;
    sram_word_u        sram_result_write_data;

    // SRAM contents and the trace kept flat with per-case offsets
    logic [data_w-1:0] input_mem [mem_depth];
    logic [data_w-1:0] weight_mem [mem_depth];
    int                case_rows[$];
    int                case_k[$];
    int                case_wcols[$];
    int                in_ofs[$];
    int                w_ofs[$];
    int                exp_ofs[$];
    logic [data_w-1:0] in_words[$];
    logic [data_w-1:0] w_words[$];
    logic [data_w-1:0] exp_words[$];

    sram_word_u result_words [int];
    int         write_count;
    int         case_total;
    logic       case_active;
    bit         trace_ok;
    int         value_errors;
    int         other_errors;
    int         cycle_limit = cycle_margin;
    int         cycle_count = 0;

    attn_proj_top i_attn_proj_top (
        .clk                       (clk),
        .reset_n                   (reset_n),
        .dut_valid                 (dut_valid),
        .dut_ready                 (dut_ready),
        .sram_input_read_address   (sram_input_read_address),
        .sram_input_read_data      (sram_input_read_data),
        .sram_weight_read_address  (sram_weight_read_address),
        .sram_weight_read_data     (sram_weight_read_data),
        .sram_result_write_enable  (sram_result_write_enable),
        .sram_result_write_address (sram_result_write_address),
        .sram_result_write_data    (sram_result_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Registered read with one cycle from address to data
    always @(posedge clk) begin
        sram_input_read_data.raw  <= input_mem[sram_input_read_address];
        sram_weight_read_data.raw <= weight_mem[sram_weight_read_address];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: dut_ready did not return within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_word(input sram_word_u actual, input sram_word_u expected,
                              input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("error at %0t: %s is %h, expected %h",
                     $time, what, actual.raw, expected.raw);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_address(input logic [addr_w-1:0] actual,
                                 input logic [addr_w-1:0] expected, input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic record_write();
        int addr;
        addr = int'(sram_result_write_address);
        if (!case_active) begin
            other_errors++;
            $display("result write to address %0d while no case was running", addr);
        end else if (addr >= case_total) begin
            other_errors++;
            $display("result write to address %0d lies beyond the last address %0d",
                     addr, case_total - 1);
        end else if (result_words.exists(addr)) begin
            other_errors++;
            $display("result address %0d was written more than once", addr);
        end else begin
            result_words[addr] = sram_result_write_data;
            write_count++;
        end
    endtask

    // Inputs change and outputs are sampled 1 ns after each clock
    task automatic step();
        @(posedge clk);
        #1;
        if (sram_result_write_enable) begin
            record_write();
        end
    endtask

    task automatic read_trace();
        int                fd;
        int                code;
        int                n_cases;
        int                r;
        int                k;
        int                w;
        logic [data_w-1:0] word;
        logic [8*128-1:0]  skip_line;
        trace_ok = 1'b0;
        fd = $fopen("bench/proj_trace.txt", "r");
        if (fd != 0) begin
            trace_ok = 1'b1;
            // Two column description lines head the file
            code = $fgets(skip_line, fd);
            code = $fgets(skip_line, fd);
            code = $fscanf(fd, "%d", n_cases);
            if (code != 1) trace_ok = 1'b0;
            for (int c = 0; c < n_cases && trace_ok; c++) begin
                code = $fscanf(fd, "%d %d %d", r, k, w);
                if (code != 3) trace_ok = 1'b0;
                case_rows.push_back(r);
                case_k.push_back(k);
                case_wcols.push_back(w);
                in_ofs.push_back(in_words.size());
                w_ofs.push_back(w_words.size());
                exp_ofs.push_back(exp_words.size());
                for (int i = 0; i < r * k; i++) begin
                    if ($fscanf(fd, "%h", word) != 1) trace_ok = 1'b0;
                    in_words.push_back(word);
                end
                for (int i = 0; i < mats_per_case * k * w; i++) begin
                    if ($fscanf(fd, "%h", word) != 1) trace_ok = 1'b0;
                    w_words.push_back(word);
                end
                for (int i = 0; i < mats_per_case * r * w; i++) begin
                    if ($fscanf(fd, "%h", word) != 1) trace_ok = 1'b0;
                    exp_words.push_back(word);
                end
                cycle_limit = cycle_limit + mats_per_case * r * k * w + case_overhead;
            end
            $fclose(fd);
        end
    endtask

    // Unused words hold an address pattern so stray reads show up
    task automatic fill_memories();
        logic [addr_w-1:0] a_w;
        for (int a = 0; a < mem_depth; a++) begin
            a_w = addr_w'(a);
            input_mem[a_w]  = {~a_w, a_w};
            weight_mem[a_w] = {a_w, ~a_w};
        end
    endtask

    task automatic load_case(input int c);
        sram_word_u        head;
        logic [addr_w-1:0] a_w;
        fill_memories();
        head.dims.rows = dim_w'(case_rows[c]);
        head.dims.cols = dim_w'(case_k[c]);
        input_mem[header_addr] = head.raw;
        // Weight rows match the input columns
        head.dims.rows = dim_w'(case_k[c]);
        head.dims.cols = dim_w'(case_wcols[c]);
        weight_mem[header_addr] = head.raw;
        for (int i = 0; i < case_rows[c] * case_k[c]; i++) begin
            a_w = data_base + addr_w'(i);
            input_mem[a_w] = in_words[in_ofs[c] + i];
        end
        for (int i = 0; i < mats_per_case * case_k[c] * case_wcols[c]; i++) begin
            a_w = data_base + addr_w'(i);
            weight_mem[a_w] = w_words[w_ofs[c] + i];
        end
    endtask

    task automatic compare_case(input int c);
        sram_word_u expected;
        for (int i = 0; i < case_total; i++) begin
            expected.raw = exp_words[exp_ofs[c] + i];
            if (!result_words.exists(i)) begin
                other_errors++;
                $display("case %0d: result address %0d was never written", c, i);
            end else begin
                check_word(result_words[i], expected,
                           $sformatf("case %0d result word %0d", c, i));
            end
        end
    endtask

    task automatic run_case(input int c);
        load_case(c);
        result_words.delete();
        write_count = 0;
        case_total  = mats_per_case * case_rows[c] * case_wcols[c];
        case_active = 1'b1;
        // Let the idle read of address 0 pick up the new headers
        repeat (2) step();
        dut_valid = 1'b1;
        step();
        dut_valid = 1'b0;
        check_flag(dut_ready, 1'b0, $sformatf("case %0d dut_ready after start", c));
        repeat (2) step();
        // Second strobe lands while busy and must be dropped
        dut_valid = 1'b1;
        step();
        dut_valid = 1'b0;
        check_flag(dut_ready, 1'b0, $sformatf("case %0d dut_ready while busy", c));
        while (dut_ready !== 1'b1) begin
            step();
        end
        case_active = 1'b0;
        check_address(sram_input_read_address, header_addr,
                      $sformatf("case %0d input read address after completion", c));
        check_address(sram_weight_read_address, header_addr,
                      $sformatf("case %0d weight read address after completion", c));
        if (write_count != case_total) begin
            other_errors++;
            $display("case %0d: %0d result writes before dut_ready rose, %0d expected",
                     c, write_count, case_total);
        end
        repeat (4) begin
            step();
            check_flag(dut_ready, 1'b1, $sformatf("case %0d dut_ready after completion", c));
        end
        compare_case(c);
    endtask

    initial begin
        reset_n      = 1'b0;
        dut_valid    = 1'b0;
        case_active  = 1'b0;
        case_total   = 0;
        write_count  = 0;
        value_errors = 0;
        other_errors = 0;
        read_trace();
        fill_memories();
        if (!trace_ok) begin
            $display("trace file bench/proj_trace.txt is missing or malformed");
            $display("test failed");
            $finish;
        end else begin
            repeat (16) step();
            reset_n = 1'b1;
            step();
            check_flag(dut_ready, 1'b1, "dut_ready after reset");
            check_address(sram_input_read_address, header_addr,
                          "input read address after reset");
            check_address(sram_weight_read_address, header_addr,
                          "weight read address after reset");
            repeat (4) step();
            for (int c = 0; c < case_rows.size(); c++) begin
                run_case(c);
            end
            $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
            if (value_errors + other_errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

// File: src.f
hw/proj_mem_pkg.sv
hw/proj_ctrl_pkg.sv
hw/proj_decode.sv
hw/proj_execute.sv
hw/proj_result.sv
hw/attn_proj_top.sv
bench/tb_attn_proj.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the attention projection testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f src.f --top-module tb_attn_proj -Mdir "$build_dir" -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build returned status $build_status"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation returned status $run_status"
    exit 1
fi

if grep -q "test failed" "$log_file"; then
    echo "failure reported in $log_file"
    exit 1
fi

echo "no failure reported in $log_file"
exit 0

// File: bench/proj_trace.txt
# case count, then per case: input_rows input_cols weight_cols (decimal), input words row-major,
# weight words for Q, K, V column-major, expected Q, K, V results row-major (all words hex)
4

2 3 4
00000001 00000002 00000003
00000004 00000005 00000006
00000001 00000000 00000002 00000000 00000001 00000001
00000003 00000001 00000000 00000002 00000002 00000002
00000001 00000001 00000001 00000002 00000000 00000001
00000000 00000003 00000002 00000005 00000004 00000000
0000000a 00000000 00000000 00000000 00000000 00000007
00000001 00000002 00000003 00000064 00000001 00000001
00000007 00000005 00000005 0000000c
00000010 0000000b 00000011 0000001e
00000006 00000005 0000000c 0000000d
0000000f 0000000e 0000001b 00000028
0000000a 00000015 0000000e 00000069
00000028 0000002a 00000020 0000019b

1 1 1
00000007
00000003 00010000 ffffffff
00000015 00070000 fffffff9

2 2 2
00010000 00000002 ffffffff 80000000
00010000 00000001 00000003 80000000
ffffffff ffffffff 12345678 00000000
00000001 00000003 0000ffff 00000002
00000002 00030000 7fff0000 fffffffd
fffefffe 56780000 80000001 edcba988
00010006 ffff0004 7fffffff ffff0001

3 2 1
00000001 00000002 00000003 00000004 00000005 00000006
00000001 00000001 00000002 00000000 00000000 00000003
00000003 00000007 0000000b
00000002 00000006 0000000a
00000006 0000000c 00000012
